/* design/wbh_arbiter.sv */
// fixed priority, host wins ties; grant changes only while the owner has cyc low
`timescale 1ns/1ns

module wbh_arbiter (
    input  logic             wbm_clk_i,
    input  logic             s_reset_n,
    input  wbh_pkg::wb_req_t host_req_i,
    input  wbh_pkg::wb_req_t aux_req_i,
    input  wbh_pkg::wb_rsp_t bus_rsp_i,         // shared response
    output wbh_pkg::wb_req_t bus_req_o,         // owner request
    output wbh_pkg::wb_rsp_t host_rsp_o,
    output wbh_pkg::wb_rsp_t aux_rsp_o
);
    import wbh_pkg::*;

    grant_e gnt_q;                              // owner of the last cycle
    grant_e gnt;                                // owner this cycle
    logic   host_rq;
    logic   aux_rq;
    logic   owner_cyc;                          // owner still holds the bus

    assign host_rq   = host_req_i.cyc & host_req_i.stb;  // host needs both
    assign aux_rq    = aux_req_i.stb;
    assign owner_cyc = (gnt_q == GNT_HOST) ? host_req_i.cyc : aux_req_i.cyc;

    // ------------------------------
    // grant decision
    // ------------------------------
    always_comb begin
        gnt = gnt_q;                            // keep by default
        if (!owner_cyc) begin
            if (host_rq) begin
                gnt = GNT_HOST;                 // host first on a tie
            end else if (aux_rq) begin
                gnt = GNT_AUX;
            end
        end
    end

    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            gnt_q <= GNT_HOST;
        end else begin
            gnt_q <= gnt;
        end
    end

    // ------------------------------
    // request mux
    // ------------------------------
    always_comb begin
        if (gnt == GNT_HOST) begin
            bus_req_o     = host_req_i;
            bus_req_o.stb = host_req_i.cyc & host_req_i.stb;  // stb qualified by cyc
        end else begin
            bus_req_o = aux_req_i;
        end
    end

    // response goes to the owner, the loser reads zeros
    assign host_rsp_o = (gnt == GNT_HOST) ? bus_rsp_i : '0;
    assign aux_rsp_o  = (gnt == GNT_AUX)  ? bus_rsp_i : '0;

endmodule

/* design/wbh_pkg.sv */
// single clock wishbone classic only; no burst, no tags, one transfer in flight per master
package wbh_pkg;

    // ------------------------------
    // bus widths
    // ------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;                  // one enable per byte lane

    // ------------------------------
    // address map
    // ------------------------------
    localparam int LOCAL_SEL_BIT = 19;          // adr[19] set selects local regs
    localparam int BANK_W        = 16;          // bank select register width
    localparam int BANK_LSB      = 3;           // bank_sel[15:3] forms adr[31:19]
    localparam int REG_IDX_W     = 3;           // word index, adr[4:2]

    // register reset values and constants
    localparam logic [BANK_W-1:0] BANK_SEL_RST = 16'h1000;
    localparam logic [DATA_W-1:0] HUB_ID       = 32'h5748_0001;  // read only

    // one wishbone request, master to slave
    typedef struct packed {
        logic              cyc;                 // cycle valid
        logic              stb;                 // strobe
        logic              we;                  // 1 = write
        logic [ADDR_W-1:0] adr;                 // byte address
        logic [DATA_W-1:0] dat;                 // write data
        logic [SEL_W-1:0]  sel;                 // byte enables
    } wb_req_t;

    // one wishbone response, slave to master
    typedef struct packed {
        logic [DATA_W-1:0] dat;                 // read data
        logic              ack;                 // single cycle pulse
        logic              err;                 // never with ack
    } wb_rsp_t;

    // current bus owner
    typedef enum logic {
        GNT_HOST = 1'b0,
        GNT_AUX  = 1'b1
    } grant_e;

    // local register indexes
    typedef enum logic [REG_IDX_W-1:0] {
        REG_BANK_SEL = 3'd0,                    // upper address bits for slave side
        REG_SCRATCH  = 3'd1,                    // free read/write word
        REG_ID       = 3'd2                     // hub identification
    } reg_idx_e;

endpackage

/* design/wbh_reg.sv */
// local registers; one ack per strobe, writes to REG_ID and unused indexes are dropped
`timescale 1ns/1ns

module wbh_reg (
    input  logic                          wbm_clk_i,
    input  logic                          s_reset_n,
    input  logic                          reg_cs_i,     // held until ack
    input  logic                          reg_wr_i,     // 1 = write
    input  logic [wbh_pkg::REG_IDX_W-1:0] reg_idx_i,    // word index
    input  logic [wbh_pkg::DATA_W-1:0]    reg_wdata_i,
    input  logic [wbh_pkg::SEL_W-1:0]     reg_be_i,     // byte enables
    output logic [wbh_pkg::DATA_W-1:0]    reg_rdata_o,
    output logic                          reg_ack_o,
    output logic [wbh_pkg::BANK_W-1:0]    bank_sel_o    // to slave port
);
    import wbh_pkg::*;

    reg_idx_e          idx;
    logic              acc;                     // first cycle of a strobe
    logic              wr_en;
    logic [BANK_W-1:0] bank_sel_q;
    logic [DATA_W-1:0] scratch_q;
    logic [DATA_W-1:0] rd_mux;

    assign idx   = reg_idx_e'(reg_idx_i);
    assign acc   = reg_cs_i & ~reg_ack_o;       // held cs must not ack twice
    assign wr_en = acc & reg_wr_i;

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        case (idx)
            REG_BANK_SEL: rd_mux = {{(DATA_W-BANK_W){1'b0}}, bank_sel_q};
            REG_SCRATCH:  rd_mux = scratch_q;
            REG_ID:       rd_mux = HUB_ID;
            default:      rd_mux = '0;          // unused indexes read 0
        endcase
    end

    // ------------------------------
    // write and ack
    // ------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            bank_sel_q <= BANK_SEL_RST;
            scratch_q  <= '0;
            reg_ack_o  <= 1'b0;
        end else begin
            reg_ack_o <= acc;                   // 1 cycle after the strobe
            if (wr_en && idx == REG_BANK_SEL) begin
                for (int b = 0; b < BANK_W/8; b++) begin
                    if (reg_be_i[b]) begin
                        bank_sel_q[b*8 +: 8] <= reg_wdata_i[b*8 +: 8];
                    end
                end
            end
            if (wr_en && idx == REG_SCRATCH) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (reg_be_i[b]) begin
                        scratch_q[b*8 +: 8] <= reg_wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge wbm_clk_i) begin
        if (acc) begin
            reg_rdata_o <= rd_mux;
        end
    end

    assign bank_sel_o = bank_sel_q;

endmodule

/* design/wbh_req_stage.sv */
// registers the strobe and the response; adds two cycles to every access, local err is always 0
`timescale 1ns/1ns

module wbh_req_stage (
    input  logic                       wbm_clk_i,
    input  logic                       s_reset_n,
    input  wbh_pkg::wb_req_t           bus_req_i,     // owner request
    input  logic [wbh_pkg::DATA_W-1:0] reg_rdata_i,   // local read data
    input  logic                       reg_ack_i,
    input  wbh_pkg::wb_rsp_t           slv_rsp_i,     // slave side response
    output wbh_pkg::wb_rsp_t           bus_rsp_o,     // back to arbiter
    output logic                       reg_cs_o,      // local strobe
    output logic                       slv_stb_o      // slave port strobe
);
    import wbh_pkg::*;

    logic              req_q;                   // registered strobe
    logic              local_sel;               // adr[19] decode
    wb_rsp_t           rsp_mux;                 // merged response
    logic              rsp_hit;                 // any ack/err this cycle
    logic              ack_q;
    logic              err_q;
    logic [DATA_W-1:0] dat_q;                   // last read data

    // ------------------------------
    // address decode
    // ------------------------------
    assign local_sel = bus_req_i.adr[LOCAL_SEL_BIT];
    assign reg_cs_o  = req_q & local_sel;
    assign slv_stb_o = req_q & ~local_sel;

    // pick the responder by address
    always_comb begin
        if (local_sel) begin
            rsp_mux.dat = reg_rdata_i;
            rsp_mux.ack = reg_ack_i;
            rsp_mux.err = 1'b0;                 // local block never errors
        end else begin
            rsp_mux = slv_rsp_i;
        end
    end

    assign rsp_hit = rsp_mux.ack | rsp_mux.err;

    // ------------------------------
    // strobe and response registers
    // ------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
            err_q <= 1'b0;
            dat_q <= '0;
        end else begin
            // no new strobe while a response is on its way back
            req_q <= bus_req_i.stb & ~(ack_q | err_q) & ~rsp_hit;
            ack_q <= rsp_mux.ack;               // one cycle pulse
            err_q <= rsp_mux.err;
            if (rsp_mux.ack) begin
                dat_q <= rsp_mux.dat;           // keep last data on the bus
            end
        end
    end

    assign bus_rsp_o.dat = dat_q;
    assign bus_rsp_o.ack = ack_q;
    assign bus_rsp_o.err = err_q;

endmodule

/* design/wbh_slave_port.sv */
// one slave cycle at a time; address bits 31:19 come from bank select, not from the master
`timescale 1ns/1ns

module wbh_slave_port (
    input  logic                       wbm_clk_i,
    input  logic                       s_reset_n,
    input  logic                       slv_stb_i,     // registered strobe, slave side
    input  wbh_pkg::wb_req_t           bus_req_i,     // owner request fields
    input  logic [wbh_pkg::BANK_W-1:0] bank_sel_i,
    input  wbh_pkg::wb_rsp_t           slave_rsp_i,
    output wbh_pkg::wb_req_t           slave_req_o,
    output wbh_pkg::wb_rsp_t           slv_rsp_o      // to request stage
);
    import wbh_pkg::*;

    logic              busy_q;                  // cycle open on the slave bus
    logic              start;
    logic              done;
    logic [ADDR_W-1:0] adr_xlat;                // banked address
    logic [ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0] dat_q;
    logic [SEL_W-1:0]  sel_q;
    logic              we_q;

    // {bank_sel[15:3], adr[18:0]}
    assign adr_xlat = {bank_sel_i[BANK_W-1:BANK_LSB], bus_req_i.adr[LOCAL_SEL_BIT-1:0]};

    assign start = slv_stb_i & ~busy_q;
    assign done  = busy_q & (slave_rsp_i.ack | slave_rsp_i.err);

    // ------------------------------
    // cycle control
    // ------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;                     // drop cyc/stb on the response
        end
    end

    // request fields held for the whole cycle
    always_ff @(posedge wbm_clk_i) begin
        if (start) begin
            adr_q <= adr_xlat;
            dat_q <= bus_req_i.dat;
            sel_q <= bus_req_i.sel;
            we_q  <= bus_req_i.we;
        end
    end

    assign slave_req_o.cyc = busy_q;
    assign slave_req_o.stb = busy_q;
    assign slave_req_o.we  = we_q;
    assign slave_req_o.adr = adr_q;
    assign slave_req_o.dat = dat_q;
    assign slave_req_o.sel = sel_q;

    // response passes through, only while a cycle is open
    assign slv_rsp_o.dat = slave_rsp_i.dat;
    assign slv_rsp_o.ack = slave_rsp_i.ack & busy_q;
    assign slv_rsp_o.err = slave_rsp_i.err & busy_q;

endmodule

/* design/wbh_top.sv */
// all logic on wbm_clk_i with synchronous active low s_reset_n; slave side shares this clock
`timescale 1ns/1ns

module wbh_top (
    input  logic             wbm_clk_i,         // single system clock
    input  logic             s_reset_n,         // sync reset, active low
    input  wbh_pkg::wb_req_t host_req_i,        // host master request
    input  wbh_pkg::wb_req_t aux_req_i,         // bridge side master request
    input  wbh_pkg::wb_rsp_t slave_rsp_i,       // from outgoing slave
    output wbh_pkg::wb_rsp_t host_rsp_o,
    output wbh_pkg::wb_rsp_t aux_rsp_o,
    output wbh_pkg::wb_req_t slave_req_o        // outgoing slave cycle
);
    import wbh_pkg::*;

    // ------------------------------
    // internal nets
    // ------------------------------
    wb_req_t           bus_req;                 // owner request after mux
    wb_rsp_t           bus_rsp;                 // registered response to owner
    wb_rsp_t           slv_rsp;                 // slave response, in flight only
    logic              reg_cs;
    logic              slv_stb;
    logic [DATA_W-1:0] reg_rdata;
    logic              reg_ack;
    logic [BANK_W-1:0] bank_sel;                // upper address source

    wbh_arbiter u_arb (
        .wbm_clk_i  (wbm_clk_i),
        .s_reset_n  (s_reset_n),
        .host_req_i (host_req_i),
        .aux_req_i  (aux_req_i),
        .bus_rsp_i  (bus_rsp),
        .bus_req_o  (bus_req),
        .host_rsp_o (host_rsp_o),
        .aux_rsp_o  (aux_rsp_o)
    );

    wbh_req_stage u_req (
        .wbm_clk_i   (wbm_clk_i),
        .s_reset_n   (s_reset_n),
        .bus_req_i   (bus_req),
        .reg_rdata_i (reg_rdata),
        .reg_ack_i   (reg_ack),
        .slv_rsp_i   (slv_rsp),
        .bus_rsp_o   (bus_rsp),
        .reg_cs_o    (reg_cs),
        .slv_stb_o   (slv_stb)
    );

    wbh_reg u_reg (
        .wbm_clk_i   (wbm_clk_i),
        .s_reset_n   (s_reset_n),
        .reg_cs_i    (reg_cs),
        .reg_wr_i    (bus_req.we),
        .reg_idx_i   (bus_req.adr[REG_IDX_W+1:2]),   // word index
        .reg_wdata_i (bus_req.dat),
        .reg_be_i    (bus_req.sel),
        .reg_rdata_o (reg_rdata),
        .reg_ack_o   (reg_ack),
        .bank_sel_o  (bank_sel)
    );

    wbh_slave_port u_slv (
        .wbm_clk_i   (wbm_clk_i),
        .s_reset_n   (s_reset_n),
        .slv_stb_i   (slv_stb),
        .bus_req_i   (bus_req),
        .bank_sel_i  (bank_sel),
        .slave_rsp_i (slave_rsp_i),
        .slave_req_o (slave_req_o),
        .slv_rsp_o   (slv_rsp)
    );

endmodule

/* tests/wbh_checker.sv */
// protocol assertions on the hub ports, bound into every wbh_top instance
`timescale 1ns/1ns

module wbh_checker (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  wbh_pkg::wb_rsp_t host_rsp_i,
    input  wbh_pkg::wb_rsp_t aux_rsp_i,
    input  wbh_pkg::wb_req_t slave_req_i,
    input  wbh_pkg::wb_rsp_t slave_rsp_i
);
    import wbh_pkg::*;

    // ------------------------------
    // ack and err exclusive
    // ------------------------------
    a_host_ack_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(host_rsp_i.ack && host_rsp_i.err)) else $error("host ack and err together");

    a_aux_ack_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(aux_rsp_i.ack && aux_rsp_i.err)) else $error("aux ack and err together");

    a_slv_ack_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(slave_rsp_i.ack && slave_rsp_i.err)) else $error("slave ack and err together");

    // slave stb must hold until the slave answers
    a_slv_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (slave_req_i.stb && !(slave_rsp_i.ack || slave_rsp_i.err)) |=> slave_req_i.stb)
        else $error("slave stb dropped before ack or err");

    // only the owner ever gets an ack
    a_one_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(host_rsp_i.ack && aux_rsp_i.ack)) else $error("host and aux acked together");

endmodule

bind wbh_top wbh_checker u_chk (
    .clk_i       (wbm_clk_i),
    .rst_n_i     (s_reset_n),
    .host_rsp_i  (host_rsp_o),
    .aux_rsp_i   (aux_rsp_o),
    .slave_req_i (slave_req_o),
    .slave_rsp_i (slave_rsp_i)
);

/* tests/wbh_clk_gen.sv */
// free running clock from time 0; reset low for RST_CYCLES rising edges, released after a edge
`timescale 1ns/1ns

module wbh_clk_gen #(
    parameter int PERIOD     = 100,             // ns
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o                        // sync, active low
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        forever #(PERIOD/2) clk_o = ~clk_o;
    end

    initial begin
        repeat (RST_CYCLES) @(posedge clk_o);
        #(PERIOD/10) rst_n_o = 1'b1;            // release away from the edge
    end

endmodule

/* tests/wbh_tb.sv */
// directed tests; slave model memory is 32 words indexed by adr[6:2], err for adr[31:29] == 7
`timescale 1ns/1ns

module wbh_tb;
    import wbh_pkg::*;

    localparam int          CLK_PERIOD  = 100;
    localparam int          DRV_DLY     = 10;    // drive after rising edge
    localparam int          NUM_XFERS   = 18;    // transactions issued by all tests
    localparam int          XFER_CYCLES = 20;
    localparam logic [31:0] SEED        = 32'h3c7f4a04;
    localparam logic [31:0] LOC         = 32'h0008_0000;  // adr[19] set

    logic    clk;
    logic    rst_n;
    wb_req_t host_req;
    wb_req_t aux_req;
    wb_rsp_t slave_rsp;
    wb_rsp_t host_rsp;
    wb_rsp_t aux_rsp;
    wb_req_t slave_req;

    // slave model state
    logic [31:0] mem [0:31];
    wb_req_t     req_s;                          // slave request seen at the edge
    logic        sl_busy;
    int unsigned sl_wait;
    logic [31:0] last_adr;
    int          err_cnt;
    int          done_order;                     // arbitration completion order

    wbh_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    wbh_top dut0 (
        .wbm_clk_i   (clk),
        .s_reset_n   (rst_n),
        .host_req_i  (host_req),
        .aux_req_i   (aux_req),
        .slave_rsp_i (slave_rsp),
        .host_rsp_o  (host_rsp),
        .aux_rsp_o   (aux_rsp),
        .slave_req_o (slave_req)
    );

    // ------------------------------
    // behavioral slave
    // ------------------------------
    initial begin
        for (int i = 0; i < 32; i++) begin
            mem[i] = (i * 32'h0101_0101) ^ 32'h5a5a_0000;   // differs for every word
        end
    end

    always @(posedge clk) begin
        req_s = slave_req;                       // flop outputs, stable before NBA
        #DRV_DLY;
        if (!rst_n) begin
            slave_rsp = '0;
            sl_busy   = 1'b0;
        end else if (slave_rsp.ack || slave_rsp.err) begin
            slave_rsp = '0;                      // single cycle pulse
        end else if (req_s.cyc && req_s.stb) begin
            if (!sl_busy) begin
                sl_busy = 1'b1;
                sl_wait = $urandom % 4;          // 0 to 3 wait cycles
            end
            if (sl_wait == 0) begin
                sl_busy  = 1'b0;
                last_adr = req_s.adr;
                if (req_s.adr[31:29] == 3'b111) begin
                    slave_rsp.err = 1'b1;
                end else begin
                    slave_rsp.ack = 1'b1;
                    if (req_s.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (req_s.sel[b]) begin
                                mem[req_s.adr[6:2]][b*8 +: 8] = req_s.dat[b*8 +: 8];
                            end
                        end
                    end else begin
                        slave_rsp.dat = mem[req_s.adr[6:2]];
                    end
                end
            end else begin
                sl_wait--;
            end
        end
    end

    // ------------------------------
    // check and bus tasks
    // ------------------------------
    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            err_cnt++;
            $display("FAIL %s: got %h expected %h", name, act, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one classic cycle on host (port 0) or aux (port 1), cycles counted to the ack edge
    task automatic run_xfer(input int port, input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel,
                            output logic [31:0] rdat, output logic ack, output logic err,
                            output int cycles);
        wb_req_t r;
        wb_rsp_t s;
        wb_rsp_t other;
        r      = '0;
        r.cyc  = 1'b1;
        r.stb  = 1'b1;
        r.we   = we;
        r.adr  = adr;
        r.dat  = dat;
        r.sel  = sel;
        cycles = 0;
        @(posedge clk);
        #DRV_DLY;
        if (port == 0) host_req = r;
        else aux_req = r;
        @(posedge clk);                          // stb sampled here
        do begin
            @(negedge clk);
            cycles++;
            s     = (port == 0) ? host_rsp : aux_rsp;
            other = (port == 0) ? aux_rsp : host_rsp;
            @(posedge clk);
        end while (!(s.ack || s.err));
        check_val("other_dat", other.dat, 32'h0);    // loser sees nothing
        check_val("other_ack_err", {other.ack, other.err}, 32'h0);
        rdat = s.dat;
        ack  = s.ack;
        err  = s.err;
        #DRV_DLY;
        if (port == 0) host_req = '0;
        else aux_req = '0;
    endtask

    task automatic reg_rd(input logic [2:0] idx, output logic [31:0] rdat, output int cycles);
        logic ack;
        logic err;
        run_xfer(0, 1'b0, LOC | (idx << 2), 32'h0, 4'hf, rdat, ack, err, cycles);
        check_val("local_ack", ack, 1);
        check_val("local_err", err, 0);
    endtask

    task automatic reg_wr(input logic [2:0] idx, input logic [31:0] d, input logic [3:0] sel);
        logic [31:0] rdat;
        logic        ack;
        logic        err;
        int          cyc;
        run_xfer(0, 1'b1, LOC | (idx << 2), d, sel, rdat, ack, err, cyc);
        check_val("local_ack", ack, 1);
        check_val("local_err", err, 0);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic reset_values();
        logic [31:0] d;
        int          cyc;
        reg_rd(REG_BANK_SEL, d, cyc);
        check_val("bank_sel", d, 32'h0000_1000);
        check_val("local_latency", cyc, 3);
        reg_rd(REG_SCRATCH, d, cyc);
        check_val("scratch", d, 32'h0);
        reg_rd(REG_ID, d, cyc);
        check_val("hub_id", d, 32'h5748_0001);
    endtask

    task automatic byte_enable_writes();
        logic [31:0] d;
        int          cyc;
        reg_wr(REG_SCRATCH, 32'h1122_3344, 4'b1111);
        reg_wr(REG_SCRATCH, 32'hAABB_CCDD, 4'b0101);
        reg_rd(REG_SCRATCH, d, cyc);
        check_val("scratch", d, 32'h11BB_33DD);
        reg_wr(REG_ID, 32'hFFFF_FFFF, 4'b1111);   // read only
        reg_rd(REG_ID, d, cyc);
        check_val("hub_id", d, 32'h5748_0001);
    endtask

    task automatic bank_translation();
        logic [31:0] d;
        logic        ack;
        logic        err;
        int          cyc;
        logic [15:0] bank;
        bank = 16'h246D;                         // low 3 bits unused by the slave address
        reg_wr(REG_BANK_SEL, {16'h0, bank}, 4'b0011);
        run_xfer(0, 1'b1, 32'h1234_0010, 32'hCAFE_0123, 4'hf, d, ack, err, cyc);
        check_val("slave_ack", ack, 1);
        check_val("slave_adr", last_adr, 32'h246C_0010);   // 0x48d on top, 0x40010 below
        run_xfer(1, 1'b0, 32'h1234_0010, 32'h0, 4'hf, d, ack, err, cyc);
        check_val("slave_ack", ack, 1);
        check_val("slave_rdata", d, 32'hCAFE_0123);
    endtask

    task automatic error_responses();
        logic [31:0] d;
        logic        ack;
        logic        err;
        int          cyc;
        reg_wr(REG_BANK_SEL, 32'h0000_E000, 4'b0011);   // adr[31:29] becomes 7
        run_xfer(0, 1'b0, 32'h0000_0020, 32'h0, 4'hf, d, ack, err, cyc);
        check_val("slave_err", err, 1);
        check_val("slave_ack", ack, 0);
        run_xfer(1, 1'b1, 32'h0000_0024, 32'h1234_5678, 4'hf, d, ack, err, cyc);
        check_val("aux_err", err, 1);
        check_val("aux_ack", ack, 0);
        reg_rd(REG_SCRATCH, d, cyc);            // local never errors
        reg_wr(REG_BANK_SEL, 32'h0000_1000, 4'b0011);
    endtask

    task automatic arbitration_order();
        logic [31:0] hd;
        logic [31:0] ad;
        logic        hack;
        logic        aack;
        logic        herr;
        logic        aerr;
        int          hcyc;
        int          acyc;
        int          horder;
        int          aorder;
        done_order = 0;
        fork
            begin
                run_xfer(0, 1'b0, LOC | (REG_ID << 2), 32'h0, 4'hf, hd, hack, herr, hcyc);
                horder = done_order;
                done_order++;
            end
            begin
                run_xfer(1, 1'b0, LOC | (REG_SCRATCH << 2), 32'h0, 4'hf, ad, aack, aerr, acyc);
                aorder = done_order;
                done_order++;
            end
        join
        check_val("host_order", horder, 0);
        check_val("aux_order", aorder, 1);
        check_val("host_rdata", hd, 32'h5748_0001);
        check_val("aux_rdata", ad, 32'h11BB_33DD);
        check_val("host_ack", hack, 1);
        check_val("aux_ack", aack, 1);
    endtask

    // ------------------------------
    // run control
    // ------------------------------
    initial begin
        #(CLK_PERIOD * XFER_CYCLES * NUM_XFERS);
        $display("timeout: transactions did not complete in time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(SEED));
        err_cnt   = 0;
        host_req  = '0;
        aux_req   = '0;
        slave_rsp = '0;
        sl_busy   = 1'b0;
        sl_wait   = 0;
        last_adr  = '0;
        @(posedge rst_n);
        check_val("host_ack_err_rst", {host_rsp.ack, host_rsp.err}, 32'h0);
        check_val("aux_ack_err_rst", {aux_rsp.ack, aux_rsp.err}, 32'h0);
        check_val("slave_cyc_rst", {slave_req.cyc, slave_req.stb}, 32'h0);
        reset_values();
        byte_enable_writes();
        bank_translation();
        error_responses();
        arbitration_order();
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/wbh_pkg.sv
design/wbh_arbiter.sv
design/wbh_req_stage.sv
design/wbh_reg.sv
design/wbh_slave_port.sv
design/wbh_top.sv
tests/wbh_clk_gen.sv
tests/wbh_checker.sv
tests/wbh_tb.sv
